//--- pr_cfg.svh
// --------------------
// sizes and codes shared by the accelerator and its testbench
// RTL is hard-wired to 8 elements in 4 lanes, so edit the datapath with these
// --------------------
`ifndef PR_CFG_SVH
`define PR_CFG_SVH

// vector geometry
`define PR_N          8
`define PR_LANES      4

// datapath widths
`define PR_ELEM_W     8
`define PR_WORD_W     32
`define PR_ADDR_W     32

// control register map
`define PR_REG_GO     0
`define PR_REG_BASE_G 1
`define PR_REG_BASE_R 2
`define PR_REG_NROUND 4

// memory message types
`define PR_MEM_RD     0
`define PR_MEM_WR     1

`endif

//--- pr_pkg.sv
// --------------------
// vector typedefs for the pagerank accelerator
// widths come from the config header
// --------------------
`default_nettype none

`include "pr_cfg.svh"

package pr_pkg;

  // one vector or matrix element
  typedef logic [`PR_ELEM_W-1:0] elem_t;

  // memory and control data word, four lanes
  typedef logic [`PR_WORD_W-1:0] word_t;

  // byte address
  typedef logic [`PR_ADDR_W-1:0] addr_t;

  // round counter, same width as the nround register
  typedef logic [`PR_WORD_W-1:0] count_t;

  // memory message type field
  typedef logic [2:0] mem_type_t;

  // lanes 0-3 or 4-7 of a row or vector
  typedef logic [0:0] half_t;

  // element index inside a vector
  typedef logic [$clog2(`PR_N)-1:0] idx_t;

endpackage

`default_nettype wire

//--- pr_cfg_regs.sv
// --------------------
// control port decode, zero-latency responses while idle
// reads always return data 0, requests stall while busy
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "pr_cfg.svh"

module pr_cfg_regs (
  input  logic           clk,
  input  logic           reset,
  input  logic           pr_req_val,
  input  logic           pr_req_type,
  input  pr_pkg::addr_t  pr_req_addr,
  input  pr_pkg::word_t  pr_req_data,
  input  logic           pr_resp_rdy,
  input  logic           busy,
  output logic           pr_req_rdy,
  output logic           pr_resp_val,
  output logic           pr_resp_type,
  output pr_pkg::word_t  pr_resp_data,
  output logic           go,
  output pr_pkg::addr_t  base_g,
  output pr_pkg::addr_t  base_r,
  output pr_pkg::count_t nround
);

  // request type code for a write
  localparam logic req_wr = 1'b1;

  logic req_fire;
  logic wr_fire;

  // --------------------
  // handshake
  // --------------------

  // request and response pass together while idle
  assign pr_req_rdy  = !busy && pr_resp_rdy;
  assign pr_resp_val = !busy && pr_req_val;

  assign req_fire = pr_req_val && pr_req_rdy;
  assign wr_fire  = req_fire && (pr_req_type == req_wr);

  // response echoes the type, data is always 0
  assign pr_resp_type = pr_req_type;
  assign pr_resp_data = '0;

  // one-cycle start strobe
  assign go = wr_fire && (pr_req_addr == `PR_REG_GO);

  // --------------------
  // config registers
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      base_g <= '0;
      base_r <= '0;
      nround <= '0;
    end else if (wr_fire) begin
      case (pr_req_addr)
        `PR_REG_BASE_G: base_g <= pr_req_data;
        `PR_REG_BASE_R: base_r <= pr_req_data;
        `PR_REG_NROUND: nround <= pr_req_data;
        // go and unmapped addresses store nothing
        default: ;
      endcase
    end
  end

  // the scheduler leaves idle on the edge after go
  a_go_busy: assert property (@(posedge clk) disable iff (reset)
    go |=> busy);

endmodule

`default_nettype wire

//--- pr_vec_bank.sv
// --------------------
// two R banks, source and destination swap through src_bank
// no guard against load_r and store_res in the same cycle
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "pr_cfg.svh"

module pr_vec_bank (
  input  logic          clk,
  input  logic          reset,
  input  pr_pkg::word_t mem_resp_data,
  input  logic          load_r,
  input  logic          store_res,
  input  pr_pkg::half_t half,
  input  pr_pkg::idx_t  row,
  input  logic          src_bank,
  input  pr_pkg::elem_t res,
  output pr_pkg::word_t operands,
  output pr_pkg::word_t wr_data
);

  import pr_pkg::*;

  // bits of the lane index inside a half
  localparam int lane_w = $clog2(`PR_LANES);

  // bank[b][e], element e of bank b
  elem_t bank [2][`PR_N];
  word_t src_half;
  logic  dst_bank;

  // results go to the bank not being read
  assign dst_bank = ~src_bank;

  // --------------------
  // bank update
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < 2; b++) begin
        for (int e = 0; e < `PR_N; e++) begin
          bank[b][e] <= '0;
        end
      end
    end else begin
      // one memory word fills four lanes of the selected half
      if (load_r) begin
        for (int l = 0; l < `PR_LANES; l++) begin
          bank[src_bank][{half, lane_w'(l)}] <= mem_resp_data[l*`PR_ELEM_W +: `PR_ELEM_W];
        end
      end
      // finished row element
      if (store_res) begin
        bank[dst_bank][row] <= res;
      end
    end
  end

  // --------------------
  // read side
  // --------------------

  // lane l of the word is element 4*half + l, same packing as memory
  always_comb begin
    for (int l = 0; l < `PR_LANES; l++) begin
      src_half[l*`PR_ELEM_W +: `PR_ELEM_W] = bank[src_bank][{half, lane_w'(l)}];
    end
  end

  // multiplier operands
  assign operands = src_half;

  // write-back data, only read in the write phase
  assign wr_data = src_half;

endmodule

`default_nettype wire

//--- pr_mac.sv
// --------------------
// four-lane multiply-accumulate, all arithmetic wraps mod 256
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "pr_cfg.svh"

module pr_mac (
  input  logic          clk,
  input  logic          reset,
  input  pr_pkg::word_t operands,
  input  pr_pkg::word_t g_word,
  input  logic          load_g,
  input  logic          acc_clear,
  output pr_pkg::elem_t res
);

  import pr_pkg::*;

  elem_t acc;
  elem_t lane_sum;

  // sum of the four lane products, high bits dropped
  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < `PR_LANES; l++) begin
      lane_sum = lane_sum + elem_t'(operands[l*`PR_ELEM_W +: `PR_ELEM_W] *
                                    g_word[l*`PR_ELEM_W +: `PR_ELEM_W]);
    end
  end

  // row accumulator
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (acc_clear) begin
      acc <= '0;
    end else if (load_g) begin
      acc <= acc + lane_sum;
    end
  end

  assign res = acc;

endmodule

`default_nettype wire

//--- pr_sched.sv
// --------------------
// sequencing FSM, one memory request in flight at a time
// assumes two halves per row, nround 0 writes R back unchanged
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "pr_cfg.svh"

module pr_sched (
  input  logic              clk,
  input  logic              reset,
  input  logic              go,
  input  pr_pkg::addr_t     base_g,
  input  pr_pkg::addr_t     base_r,
  input  pr_pkg::count_t    nround,
  input  logic              mem_req_rdy,
  input  logic              mem_resp_val,
  output logic              busy,
  output logic              mem_req_val,
  output logic              mem_resp_rdy,
  output pr_pkg::mem_type_t mem_req_type,
  output pr_pkg::addr_t     mem_req_addr,
  output logic              load_r,
  output logic              load_g,
  output logic              acc_clear,
  output logic              store_res,
  output pr_pkg::half_t     half,
  output pr_pkg::idx_t      row,
  output logic              src_bank
);

  import pr_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_R,
    WAIT_R,
    READ_G,
    WAIT_G,
    STORE,
    WRITE,
    WAIT_W
  } state_t;

  state_t state;
  state_t state_next;
  count_t round;

  logic req_fire;
  logic resp_fire;
  logic last_half;
  logic last_row;
  logic last_round;

  assign req_fire  = mem_req_val && mem_req_rdy;
  assign resp_fire = mem_resp_val && mem_resp_rdy;

  assign last_half  = (half == 1'b1);
  assign last_row   = (row == idx_t'(`PR_N - 1));
  assign last_round = (round + count_t'(1) == nround);

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (go) state_next = LOAD_R;
      end
      LOAD_R: begin
        if (req_fire) state_next = WAIT_R;
      end
      WAIT_R: begin
        if (resp_fire) begin
          if (!last_half) begin
            state_next = LOAD_R;
          end else if (nround == '0) begin
            // nothing to compute, straight to write-back
            state_next = WRITE;
          end else begin
            state_next = READ_G;
          end
        end
      end
      READ_G: begin
        if (req_fire) state_next = WAIT_G;
      end
      WAIT_G: begin
        if (resp_fire) state_next = last_half ? STORE : READ_G;
      end
      STORE: begin
        state_next = (last_row && last_round) ? WRITE : READ_G;
      end
      WRITE: begin
        if (req_fire) state_next = WAIT_W;
      end
      WAIT_W: begin
        if (resp_fire) state_next = last_half ? IDLE : WRITE;
      end
      default: state_next = IDLE;
    endcase
  end

  // --------------------
  // state and counters
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      round    <= '0;
      row      <= '0;
      half     <= '0;
      src_bank <= 1'b0;
    end else begin
      state <= state_next;
      case (state)
        IDLE: begin
          if (go) begin
            round    <= '0;
            row      <= '0;
            half     <= '0;
            src_bank <= 1'b0;
          end
        end
        // every response moves to the other half
        // so each phase ends back on half 0
        WAIT_R, WAIT_G, WAIT_W: begin
          if (resp_fire) half <= ~half;
        end
        STORE: begin
          // 3-bit row wraps to 0 after the last row
          row <= row + 1'b1;
          if (last_row) begin
            round    <= round + count_t'(1);
            // new vector becomes the source
            src_bank <= ~src_bank;
          end
        end
        default: ;
      endcase
    end
  end

  // --------------------
  // outputs
  // --------------------

  assign busy = (state != IDLE);

  assign mem_req_val  = (state == LOAD_R) || (state == READ_G) || (state == WRITE);
  assign mem_resp_rdy = (state == WAIT_R) || (state == WAIT_G) || (state == WAIT_W);

  // type held through the wait so the response can be matched
  assign mem_req_type = ((state == WRITE) || (state == WAIT_W)) ?
                        mem_type_t'(`PR_MEM_WR) : mem_type_t'(`PR_MEM_RD);

  // G at base_g + 8*row + 4*half, R at base_r + 4*half
  assign mem_req_addr = (state == READ_G) ? base_g + addr_t'({row, half, 2'b00}) :
                                            base_r + addr_t'({half, 2'b00});

  // strobes, banks and accumulator act on the next edge
  assign load_r    = (state == WAIT_R) && resp_fire;
  assign load_g    = (state == WAIT_G) && resp_fire;
  assign acc_clear = (state == READ_G) && (half == 1'b0);
  assign store_res = (state == STORE);

  // request stays up and stable under back-pressure
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=>
      mem_req_val && $stable(mem_req_addr) && $stable(mem_req_type));

  // memory answers only a request already sent
  a_resp_wait: assert property (@(posedge clk) disable iff (reset)
    mem_resp_val |-> (state inside {WAIT_R, WAIT_G, WAIT_W}));

endmodule

`default_nettype wire

//--- pr_top.sv
// --------------------
// pagerank accelerator top, control port and one memory port
// --------------------
`timescale 1ns/1ps
`default_nettype none

module pr_top (
  input  logic              clk,
  input  logic              reset,
  // control request
  input  logic              pr_req_val,
  output logic              pr_req_rdy,
  input  logic              pr_req_type,
  input  pr_pkg::addr_t     pr_req_addr,
  input  pr_pkg::word_t     pr_req_data,
  // control response
  output logic              pr_resp_val,
  input  logic              pr_resp_rdy,
  output logic              pr_resp_type,
  output pr_pkg::word_t     pr_resp_data,
  // memory request
  output logic              mem_req_val,
  input  logic              mem_req_rdy,
  output pr_pkg::mem_type_t mem_req_type,
  output pr_pkg::addr_t     mem_req_addr,
  output pr_pkg::word_t     mem_req_data,
  // memory response
  input  logic              mem_resp_val,
  output logic              mem_resp_rdy,
  input  pr_pkg::mem_type_t mem_resp_type,
  input  pr_pkg::word_t     mem_resp_data
);

  import pr_pkg::*;

  logic   go;
  logic   busy;
  addr_t  base_g;
  addr_t  base_r;
  count_t nround;

  // scheduler strobes and selectors
  logic   load_r;
  logic   load_g;
  logic   acc_clear;
  logic   store_res;
  half_t  half;
  idx_t   row;
  logic   src_bank;

  word_t  operands;
  elem_t  res;

  pr_cfg_regs u_cfg (
    .clk          (clk),
    .reset        (reset),
    .pr_req_val   (pr_req_val),
    .pr_req_type  (pr_req_type),
    .pr_req_addr  (pr_req_addr),
    .pr_req_data  (pr_req_data),
    .pr_resp_rdy  (pr_resp_rdy),
    .busy         (busy),
    .pr_req_rdy   (pr_req_rdy),
    .pr_resp_val  (pr_resp_val),
    .pr_resp_type (pr_resp_type),
    .pr_resp_data (pr_resp_data),
    .go           (go),
    .base_g       (base_g),
    .base_r       (base_r),
    .nround       (nround)
  );

  pr_sched u_sched (
    .clk          (clk),
    .reset        (reset),
    .go           (go),
    .base_g       (base_g),
    .base_r       (base_r),
    .nround       (nround),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .busy         (busy),
    .mem_req_val  (mem_req_val),
    .mem_resp_rdy (mem_resp_rdy),
    .mem_req_type (mem_req_type),
    .mem_req_addr (mem_req_addr),
    .load_r       (load_r),
    .load_g       (load_g),
    .acc_clear    (acc_clear),
    .store_res    (store_res),
    .half         (half),
    .row          (row),
    .src_bank     (src_bank)
  );

  // write-back data comes straight from the source bank
  pr_vec_bank u_bank (
    .clk           (clk),
    .reset         (reset),
    .mem_resp_data (mem_resp_data),
    .load_r        (load_r),
    .store_res     (store_res),
    .half          (half),
    .row           (row),
    .src_bank      (src_bank),
    .res           (res),
    .operands      (operands),
    .wr_data       (mem_req_data)
  );

  // G words are used as they arrive, never stored
  pr_mac u_mac (
    .clk       (clk),
    .reset     (reset),
    .operands  (operands),
    .g_word    (mem_resp_data),
    .load_g    (load_g),
    .acc_clear (acc_clear),
    .res       (res)
  );

  // response type matches the request it answers
  a_resp_type: assert property (@(posedge clk) disable iff (reset)
    mem_resp_val && mem_resp_rdy |-> mem_resp_type == mem_req_type);

endmodule

`default_nettype wire

//--- tb_pr_mem.sv
// --------------------
// memory model, 64 words of 32 bits, byte addresses 0x00 to 0xff
// one request at a time, random response delay and ready drops
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "pr_cfg.svh"

module tb_pr_mem (
  input  logic              clk,
  input  logic              reset,
  input  logic              mem_req_val,
  output logic              mem_req_rdy,
  input  pr_pkg::mem_type_t mem_req_type,
  input  pr_pkg::addr_t     mem_req_addr,
  input  pr_pkg::word_t     mem_req_data,
  output logic              mem_resp_val,
  input  logic              mem_resp_rdy,
  output pr_pkg::mem_type_t mem_resp_type,
  output pr_pkg::word_t     mem_resp_data
);

  import pr_pkg::*;

  localparam int depth = 64;

  // word storage, also loaded and read by the top of the testbench
  word_t mem [depth];

  // requests that fell outside the array
  int bad_addr;

  // write transfers that landed in the array
  int wr_count;

  logic [31:0] lfsr;
  logic        req_taken;
  logic        resp_taken;
  mem_type_t   req_type_q;
  addr_t       req_addr_q;
  logic        pending;
  logic [3:0]  delay;
  logic [3:0]  pick;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit drawn
  task automatic draw_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[2:0], lfsr[0]};
    end
  endtask

  // --------------------
  // sample on the rising edge
  // --------------------
  always @(posedge clk) begin
    if (reset) begin
      req_taken  <= 1'b0;
      resp_taken <= 1'b0;
    end else begin
      req_taken  <= mem_req_val && mem_req_rdy;
      resp_taken <= mem_resp_val && mem_resp_rdy;
      if (mem_req_val && mem_req_rdy) begin
        req_type_q <= mem_req_type;
        req_addr_q <= mem_req_addr;
        if (mem_req_addr >= addr_t'(depth * 4)) begin
          bad_addr = bad_addr + 1;
        end else if (mem_req_type == mem_type_t'(`PR_MEM_WR)) begin
          mem[mem_req_addr[7:2]] = mem_req_data;
          wr_count = wr_count + 1;
        end
      end
    end
  end

  // --------------------
  // drive on the falling edge
  // --------------------
  initial begin
    lfsr          = 32'he52f;
    bad_addr      = 0;
    wr_count      = 0;
    pending       = 1'b0;
    delay         = '0;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_type = '0;
    mem_resp_data = '0;
    forever begin
      @(negedge clk);
      if (reset) begin
        pending      = 1'b0;
        mem_req_rdy  = 1'b0;
        mem_resp_val = 1'b0;
      end else begin
        // response accepted, free for the next request
        if (resp_taken) begin
          mem_resp_val = 1'b0;
          pending      = 1'b0;
        end
        if (req_taken) begin
          pending = 1'b1;
          draw_bits(2, delay);
        end
        if (pending && !mem_resp_val) begin
          if (delay == 0) begin
            mem_resp_val  = 1'b1;
            mem_resp_type = req_type_q;
            mem_resp_data = (req_type_q == mem_type_t'(`PR_MEM_RD)) ?
                            mem[req_addr_q[7:2]] : '0;
          end else begin
            delay = delay - 1'b1;
          end
        end
        // ready drops one cycle in four while free
        draw_bits(2, pick);
        mem_req_rdy = !pending && (pick != 0);
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_pr_top.sv
// --------------------
// testbench for pr_top, table-driven runs against a software model
// memory bases in the table must keep G and R inside 0x00 to 0xff
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "pr_cfg.svh"

module tb_pr_top;

  import pr_pkg::*;

  localparam int num_tests = 5;
  localparam int mem_words = 64;

  // --------------------
  // test table
  // --------------------
  // columns: base of G, base of R, round count, data seed, control stall
  localparam addr_t tbl_base_g [num_tests] = '{32'h00, 32'h80, 32'h40, 32'h20, 32'h60};
  localparam addr_t tbl_base_r [num_tests] = '{32'h40, 32'h48, 32'hc0, 32'h90, 32'h10};
  localparam int    tbl_nround [num_tests] = '{1, 3, 5, 0, 2};
  localparam elem_t tbl_seed   [num_tests] = '{8'h11, 8'h5a, 8'ha7, 8'h3c, 8'he1};
  localparam bit    tbl_stall  [num_tests] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

  logic      clk;
  logic      reset;
  logic      pr_req_val;
  logic      pr_req_rdy;
  logic      pr_req_type;
  addr_t     pr_req_addr;
  word_t     pr_req_data;
  logic      pr_resp_val;
  logic      pr_resp_rdy;
  logic      pr_resp_type;
  word_t     pr_resp_data;
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_type_t mem_req_type;
  addr_t     mem_req_addr;
  word_t     mem_req_data;
  logic      mem_resp_val;
  logic      mem_resp_rdy;
  mem_type_t mem_resp_type;
  word_t     mem_resp_data;

  // expected memory image
  word_t exp_mem [mem_words];
  int    err_count;
  int    fail_count;

  pr_top dut0 (
    .clk           (clk),
    .reset         (reset),
    .pr_req_val    (pr_req_val),
    .pr_req_rdy    (pr_req_rdy),
    .pr_req_type   (pr_req_type),
    .pr_req_addr   (pr_req_addr),
    .pr_req_data   (pr_req_data),
    .pr_resp_val   (pr_resp_val),
    .pr_resp_rdy   (pr_resp_rdy),
    .pr_resp_type  (pr_resp_type),
    .pr_resp_data  (pr_resp_data),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_type  (mem_req_type),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .mem_resp_type (mem_resp_type),
    .mem_resp_data (mem_resp_data)
  );

  tb_pr_mem u_mem (
    .clk           (clk),
    .reset         (reset),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_type  (mem_req_type),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .mem_resp_type (mem_resp_type),
    .mem_resp_data (mem_resp_data)
  );

  // 4 ns period
  always #2 clk = ~clk;

  task automatic report_err(input string name, input word_t exp, input word_t got);
    $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
    err_count = err_count + 1;
  endtask

  // every byte depends on its full address and the seed
  function automatic word_t fill_word(input int idx, input elem_t seed);
    word_t w;
    int    a;
    for (int l = 0; l < `PR_LANES; l++) begin
      a = idx * 4 + l;
      w[l*8 +: 8] = elem_t'(a * 37) + seed;
    end
    return w;
  endfunction

  function automatic elem_t byte_at(input addr_t a);
    return exp_mem[a[7:2]][a[1:0]*8 +: 8];
  endfunction

  task automatic load_memory(input elem_t seed);
    word_t w;
    for (int i = 0; i < mem_words; i++) begin
      w = fill_word(i, seed);
      u_mem.mem[i] = w;
      exp_mem[i]   = w;
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  // R_new[j] = sum of G[j][k] * R[k], mod 256, repeated nround times
  task automatic build_expected(input addr_t base_g, input addr_t base_r, input int nround);
    elem_t r  [`PR_N];
    elem_t rn [`PR_N];
    elem_t acc;
    addr_t a;
    for (int k = 0; k < `PR_N; k++) begin
      r[k] = byte_at(base_r + addr_t'(k));
    end
    for (int n = 0; n < nround; n++) begin
      for (int j = 0; j < `PR_N; j++) begin
        acc = '0;
        for (int k = 0; k < `PR_N; k++) begin
          acc = acc + elem_t'(byte_at(base_g + addr_t'(8 * j + k)) * r[k]);
        end
        rn[j] = acc;
      end
      r = rn;
    end
    for (int k = 0; k < `PR_N; k++) begin
      a = base_r + addr_t'(k);
      exp_mem[a[7:2]][a[1:0]*8 +: 8] = r[k];
    end
  endtask

  // register write, checks the same-cycle response
  task automatic ctrl_write(input addr_t addr, input word_t data, input bit stall);
    @(negedge clk);
    pr_req_val  = 1'b1;
    pr_req_type = 1'b1;
    pr_req_addr = addr;
    pr_req_data = data;
    pr_resp_rdy = !stall;
    // host not ready, request must be held off
    if (stall) begin
      repeat (2) begin
        #1;
        if (pr_req_rdy !== 1'b0) report_err("pr_req_rdy", 0, pr_req_rdy);
        if (pr_resp_val !== 1'b1) report_err("pr_resp_val", 1, pr_resp_val);
        @(negedge clk);
      end
      pr_resp_rdy = 1'b1;
    end
    #1;
    if (pr_req_rdy !== 1'b1) report_err("pr_req_rdy", 1, pr_req_rdy);
    if (pr_resp_val !== 1'b1) report_err("pr_resp_val", 1, pr_resp_val);
    if (pr_resp_type !== 1'b1) report_err("pr_resp_type", 1, pr_resp_type);
    if (pr_resp_data !== '0) report_err("pr_resp_data", 0, pr_resp_data);
    @(posedge clk);
    @(negedge clk);
    pr_req_val = 1'b0;
  endtask

  // read held high while busy, completes once idle again
  task automatic wait_idle_read();
    int busy_cycles;
    busy_cycles = 0;
    @(negedge clk);
    pr_req_val  = 1'b1;
    pr_req_type = 1'b0;
    pr_req_addr = `PR_REG_BASE_R;
    pr_req_data = '0;
    pr_resp_rdy = 1'b1;
    #1;
    while (pr_req_rdy !== 1'b1) begin
      if (pr_resp_val !== 1'b0) report_err("pr_resp_val", 0, pr_resp_val);
      busy_cycles = busy_cycles + 1;
      @(negedge clk);
      #1;
    end
    // a run always takes several memory round trips
    if (busy_cycles == 0) begin
      $display("accelerator did not go busy after go at t=%0t", $time);
      err_count = err_count + 1;
    end
    if (pr_resp_val !== 1'b1) report_err("pr_resp_val", 1, pr_resp_val);
    if (pr_resp_type !== 1'b0) report_err("pr_resp_type", 0, pr_resp_type);
    if (pr_resp_data !== '0) report_err("pr_resp_data", 0, pr_resp_data);
    @(posedge clk);
    @(negedge clk);
    pr_req_val = 1'b0;
  endtask

  // whole memory, R region and everything around it
  task automatic compare_memory();
    for (int i = 0; i < mem_words; i++) begin
      if (u_mem.mem[i] !== exp_mem[i]) begin
        report_err($sformatf("mem[0x%02h]", i * 4), exp_mem[i], u_mem.mem[i]);
      end
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int errs_before;
    int bad_before;
    int wr_before;
    clk         = 1'b0;
    reset       = 1'b1;
    pr_req_val  = 1'b0;
    pr_req_type = 1'b0;
    pr_req_addr = '0;
    pr_req_data = '0;
    pr_resp_rdy = 1'b0;
    err_count   = 0;
    fail_count  = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int t = 0; t < num_tests; t++) begin
      errs_before = err_count;
      bad_before  = u_mem.bad_addr;
      wr_before   = u_mem.wr_count;
      load_memory(tbl_seed[t]);
      build_expected(tbl_base_g[t], tbl_base_r[t], tbl_nround[t]);
      ctrl_write(`PR_REG_BASE_G, tbl_base_g[t], tbl_stall[t]);
      ctrl_write(`PR_REG_BASE_R, tbl_base_r[t], tbl_stall[t]);
      ctrl_write(`PR_REG_NROUND, word_t'(tbl_nround[t]), tbl_stall[t]);
      ctrl_write(`PR_REG_GO, 32'd1, 1'b0);
      wait_idle_read();
      compare_memory();
      // R goes back as whole memory words, every round count included
      if (u_mem.wr_count - wr_before != `PR_N / `PR_LANES) begin
        report_err("mem write count", `PR_N / `PR_LANES, u_mem.wr_count - wr_before);
      end
      if (u_mem.bad_addr != bad_before) begin
        $display("memory request address outside the model in test %0d", t);
        err_count = err_count + 1;
      end
      if (err_count != errs_before) fail_count = fail_count + 1;
      $display("test %0d nround %0d: %s, %0d errors", t, tbl_nround[t],
               (err_count == errs_before) ? "pass" : "fail", err_count - errs_before);
    end

    $display("tests %0d, failed %0d, errors %0d", num_tests, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog sized from the round counts, generous per round trip
  initial begin
    int cycles;
    cycles = 200;
    for (int t = 0; t < num_tests; t++) begin
      cycles = cycles + 100 + 12 * (4 + 18 * tbl_nround[t]);
    end
    #(cycles * 4);
    $display("watchdog expired after %0d cycles, the run did not finish", cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
pr_pkg.sv
pr_cfg_regs.sv
pr_vec_bank.sv
pr_mac.sv
pr_sched.sv
pr_top.sv
tb_pr_mem.sv
tb_pr_top.sv

//--- Makefile
# Verilator build and run of the pagerank testbench

TOP := tb_pr_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

obj_dir/V$(TOP): flist.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "^Test OK$$" sim.log; then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
